/* sim.f */
src/cache_pkg.sv
src/tag_cam_fa.sv
src/cache_data_mem.sv
src/cache_controller.sv
src/cache_perf_counters.sv
src/cache_fa.sv
sim/tb_mem_buffer.sv
sim/tb_cache_fa.sv

/* Bender.yml */
package:
  name: cache_fa

sources:
  - src/cache_pkg.sv
  - src/tag_cam_fa.sv
  - src/cache_data_mem.sv
  - src/cache_controller.sv
  - src/cache_perf_counters.sv
  - src/cache_fa.sv
  - target: simulation
    files:
      - sim/tb_mem_buffer.sv
      - sim/tb_cache_fa.sv

/* sim/tb_cache_fa.sv */
`timescale 1ns/1ps

module tb_cache_fa;

	import cache_pkg::*;

	localparam int           CAPACITY    = 8;
	localparam repl_policy_e POLICY      = REPL_FIFO;
	localparam int           NUM_ENTRIES = 17;
	localparam int           CYCLE_LIMIT = NUM_ENTRIES * 40;

	typedef struct packed {
		logic        rw;        // 1 write
		logic [15:0] addr;      // word address
		logic [31:0] wdata;
		logic        exp_hit;
		logic        perf;      // check counters after this row
		logic [7:0]  hits;
		logic [7:0]  misses;
		logic [7:0]  wbs;
	} entry_t;

	// rw addr wdata hit perf hits misses wbs
	entry_t stim [NUM_ENTRIES] = '{
		'{1'b0, 16'h0100, 32'h0,         1'b0, 1'b0, 8'd0, 8'd0,  8'd0},
		'{1'b0, 16'h0102, 32'h0,         1'b1, 1'b0, 8'd0, 8'd0,  8'd0},
		'{1'b1, 16'h0101, 32'h1111_0101, 1'b1, 1'b0, 8'd0, 8'd0,  8'd0},  // line 0 dirty
		'{1'b0, 16'h0101, 32'h0,         1'b1, 1'b0, 8'd0, 8'd0,  8'd0},
		'{1'b1, 16'h0200, 32'h2222_0200, 1'b0, 1'b0, 8'd0, 8'd0,  8'd0},  // write miss
		'{1'b0, 16'h0200, 32'h0,         1'b1, 1'b0, 8'd0, 8'd0,  8'd0},
		'{1'b0, 16'h0300, 32'h0,         1'b0, 1'b0, 8'd0, 8'd0,  8'd0},
		'{1'b0, 16'h0400, 32'h0,         1'b0, 1'b0, 8'd0, 8'd0,  8'd0},
		'{1'b0, 16'h0500, 32'h0,         1'b0, 1'b0, 8'd0, 8'd0,  8'd0},
		'{1'b0, 16'h0600, 32'h0,         1'b0, 1'b0, 8'd0, 8'd0,  8'd0},
		'{1'b0, 16'h0700, 32'h0,         1'b0, 1'b0, 8'd0, 8'd0,  8'd0},
		'{1'b1, 16'h0800, 32'h3333_0800, 1'b0, 1'b1, 8'd4, 8'd8,  8'd0},  // cache full
		'{1'b0, 16'h0900, 32'h0,         1'b0, 1'b0, 8'd0, 8'd0,  8'd0},  // evicts 0x0100
		'{1'b0, 16'h0101, 32'h0,         1'b0, 1'b0, 8'd0, 8'd0,  8'd0},  // evicts 0x0200
		'{1'b0, 16'h0200, 32'h0,         1'b0, 1'b0, 8'd0, 8'd0,  8'd0},  // clean victim
		'{1'b0, 16'h0801, 32'h0,         1'b1, 1'b0, 8'd0, 8'd0,  8'd0},
		'{1'b0, 16'h0800, 32'h0,         1'b1, 1'b1, 8'd6, 8'd11, 8'd2}
	};

	logic        clock = 1'b0;
	logic        arst_n, en, core_req, core_rw, core_done, core_hit;
	logic [15:0] core_add, add;
	logic [31:0] core_wdata, core_rdata, comm_cmd, comm_rsp, buf_rdata, buf_wdata;
	logic [1:0]  metric_sel;
	logic        ready_req, ready_write, ready_read, req, req_block, rw, write, read;
	logic        cmd_rw = 1'b0;         // direction of the last accepted command
	logic [31:0] shadow [65536];        // core view of memory
	bit          shadow_set [65536];
	int          cycles = 0;

	always #20 clock = ~clock;

	cache_fa #(
		.CACHE_BLOCK_CAPACITY (CAPACITY),
		.POLICY               (POLICY)
	) u_cache_fa (
		.clock_i (clock), .arst_n_i (arst_n),
		.comm_i (comm_cmd), .metric_sel_i (metric_sel), .comm_o (comm_rsp),
		.core_req_i (core_req), .core_rw_i (core_rw),
		.core_add_i (core_add), .core_data_i (core_wdata),
		.core_done_o (core_done), .core_data_o (core_rdata), .en_i (en),
		.ready_req_i (ready_req), .ready_write_i (ready_write),
		.ready_read_i (ready_read), .data_i (buf_rdata), .hit_o (core_hit),
		.req_o (req), .req_block_o (req_block), .rw_o (rw),
		.write_o (write), .read_o (read), .add_o (add), .data_o (buf_wdata)
	);

	tb_mem_buffer u_mem (
		.clock_i (clock), .req_i (req), .add_i (add),
		.write_i (write), .data_i (buf_wdata), .read_i (read),
		.ready_req_o (ready_req), .ready_write_o (ready_write),
		.ready_read_o (ready_read), .data_o (buf_rdata)
	);

	// ------------------------------------------------------------
	// reference model and compare tasks
	// ------------------------------------------------------------
	function automatic logic [31:0] fill_word(input logic [15:0] a);
		return {a ^ 16'hA5C3, ~a};      // same fill as the buffer store
	endfunction

	function automatic logic [31:0] expected_word(input logic [15:0] a);
		return shadow_set[a] ? shadow[a] : fill_word(a);
	endfunction

	task automatic stop_run();
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [BW_DATA-1:0] got, exp);
		if (got !== exp) begin
			$display("error %s got %h expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_addr(input string name, input logic [BW_WORD_ADDR-1:0] got, exp);
		if (got !== exp) begin
			$display("error %s got %h expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, exp);
		if (got !== exp) begin
			$display("error %s got %h expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_counter(input string name, input logic [31:0] got, exp);
		if (got !== exp) begin
			$display("error %s got %h expected %h", name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_state(input string name, input ctrl_state_e got, exp);
		if (got !== exp) begin
			$display("error %s got %h expected %h", name, got, exp);
			stop_run();
		end
	endtask

	always @(posedge clock) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
			stop_run();
		end
	end

	// ------------------------------------------------------------
	// buffer command monitor
	// ------------------------------------------------------------
	always @(negedge clock) begin
		if (req) begin
			check_flag("req_block_o", req_block, 1'b1);
			if (!rw)                                   // refill of the requested block
				check_addr("add_o", add, {core_add[15:2], 2'b00});
			if (ready_req)
				cmd_rw = rw;
		end
		if (write)
			check_flag("rw_o", cmd_rw, 1'b1);          // writeback words need a write command
		if (read)
			check_flag("rw_o", cmd_rw, 1'b0);
	end

	// one core request, held until done has been seen
	task automatic run_access(input entry_t e, output logic [31:0] rdata,
		output logic hit, output int lat);
		@(posedge clock);
		#2;
		core_req   = 1'b1;
		core_rw    = e.rw;
		core_add   = e.addr;
		core_wdata = e.wdata;
		lat        = 0;
		do begin
			@(negedge clock);
			lat++;
		end while (!core_done);
		rdata = core_rdata;
		hit   = core_hit;
		@(posedge clock);
		#2;
		core_req = 1'b0;
	endtask

	task automatic read_counter(input logic [1:0] sel, output logic [31:0] val);
		@(posedge clock);
		#2;
		comm_cmd   = {CMD_READ, 28'h0};
		metric_sel = sel;
		@(posedge clock);
		#2;
		comm_cmd = {CMD_NOP, 28'h0};
		@(negedge clock);
		val = comm_rsp;                 // registered reply
	endtask

	task automatic clear_counters();
		@(posedge clock);
		#2;
		comm_cmd = {CMD_CLEAR, 28'h0};
		@(posedge clock);
		#2;
		comm_cmd = {CMD_NOP, 28'h0};
	endtask

	task automatic check_counters(input logic [31:0] hits, misses, wbs);
		logic [31:0] val;
		read_counter(2'd0, val);
		check_counter("comm_o hits", val, hits);
		read_counter(2'd1, val);
		check_counter("comm_o misses", val, misses);
		read_counter(2'd2, val);
		check_counter("comm_o writebacks", val, wbs);
		read_counter(2'd3, val);
		check_counter("comm_o unused", val, '0);
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin : main
		logic [31:0] rdata;
		logic        hit;
		int          lat;
		arst_n     = 1'b0;
		en         = 1'b1;
		core_req   = 1'b0;
		core_rw    = 1'b0;
		core_add   = '0;
		core_wdata = '0;
		comm_cmd   = {CMD_NOP, 28'h0};
		metric_sel = '0;
		repeat (16) @(posedge clock);
		#2;
		arst_n = 1'b1;
		@(negedge clock);
		check_flag("core_done_o", core_done, 1'b0);
		check_flag("hit_o", core_hit, 1'b0);
		check_flag("req_o", req, 1'b0);
		check_flag("read_o", read, 1'b0);
		check_flag("write_o", write, 1'b0);
		check_counter("comm_o", comm_rsp, '0);
		check_state("state_q", u_cache_fa.u_controller.state_q, IDLE);

		for (int i = 0; i < NUM_ENTRIES; i++) begin
			run_access(stim[i], rdata, hit, lat);
			check_flag("hit_o", hit, stim[i].exp_hit);
			if (stim[i].rw) begin
				shadow[stim[i].addr]     = stim[i].wdata;
				shadow_set[stim[i].addr] = 1'b1;
			end else begin
				check_word("core_data_o", rdata, expected_word(stim[i].addr));
			end
			if (stim[i].exp_hit && lat != 3) begin     // sample edge plus two cycles
				$display("hit at %h took %0d cycles after sampling, not 2",
					stim[i].addr, lat - 1);
				stop_run();
			end
			if (stim[i].perf)
				check_counters(stim[i].hits, stim[i].misses, stim[i].wbs);
		end

		clear_counters();
		check_counters('0, '0, '0);
		$display("sim passed");
		$finish;
	end

endmodule

/* sim/tb_mem_buffer.sv */
`timescale 1ns/1ps

module tb_mem_buffer (
	input  logic        clock_i,
	input  logic        req_i,          // block command valid
	input  logic [15:0] add_i,          // block base, offset zero
	input  logic        write_i,        // writeback word strobe
	input  logic [31:0] data_i,
	input  logic        read_i,         // refill word strobe
	output logic        ready_req_o,
	output logic        ready_write_o,
	output logic        ready_read_o,
	output logic [31:0] data_o
);

	localparam bit STALL_EN = 1'b1;     // 0 keeps every ready high

	logic [31:0] store [65536];
	bit          written [65536];       // words seen from writebacks
	logic [13:0] blk_q;                 // block of the last command
	logic [1:0]  cnt_q;                 // word within that block
	logic [31:0] lfsr_q;

	// never written words read back as this
	function automatic logic [31:0] fill_word(input logic [15:0] a);
		return {a ^ 16'hA5C3, ~a};
	endfunction

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // galois, right shift
	endfunction

	function automatic logic [31:0] word_at(input logic [15:0] a);
		return written[a] ? store[a] : fill_word(a);
	endfunction

	// two bits per ready, low only when both are zero
	task automatic draw_ready(output logic rdy);
		logic b0;
		logic b1;
		b0     = lfsr_q[0];
		lfsr_q = lfsr_next(lfsr_q);
		b1     = lfsr_q[0];
		lfsr_q = lfsr_next(lfsr_q);
		rdy    = !STALL_EN || b0 || b1;
	endtask

	initial begin
		lfsr_q        = 32'h250;
		blk_q         = '0;
		cnt_q         = '0;
		ready_req_o   = 1'b0;
		ready_write_o = 1'b0;
		ready_read_o  = 1'b0;
		data_o        = '0;
	end

	// ------------------------------------------------------------
	// handshakes seen mid-cycle, DUT outputs settled by then
	// ------------------------------------------------------------
	always @(negedge clock_i) begin
		if (req_i && ready_req_o) begin     // command accepted
			blk_q = add_i[15:2];
			cnt_q = '0;
		end
		if (write_i) begin
			store[{blk_q, cnt_q}]   = data_i;
			written[{blk_q, cnt_q}] = 1'b1;
			cnt_q                   = cnt_q + 1'b1;
		end
		if (read_i)
			cnt_q = cnt_q + 1'b1;            // word taken at the coming edge
	end

	always @(posedge clock_i) begin
		#2;
		draw_ready(ready_req_o);
		draw_ready(ready_write_o);
		draw_ready(ready_read_o);
		data_o = word_at({blk_q, cnt_q});    // next refill word
	end

endmodule

/* src/cache_fa.sv */
`timescale 1ns/1ps

module cache_fa #(
	parameter int                      CACHE_BLOCK_CAPACITY = 8,
	parameter cache_pkg::repl_policy_e POLICY               = cache_pkg::REPL_FIFO
)(
	input  logic                               clock_i,
	input  logic                               arst_n_i,
	input  logic [31:0]                        comm_i,
	input  logic [1:0]                         metric_sel_i,
	output logic [31:0]                        comm_o,
	input  logic                               core_req_i,
	input  logic                               core_rw_i,
	input  logic [cache_pkg::BW_WORD_ADDR-1:0] core_add_i,
	input  logic [cache_pkg::BW_DATA-1:0]      core_data_i,
	output logic                               core_done_o,
	output logic [cache_pkg::BW_DATA-1:0]      core_data_o,
	input  logic                               en_i,
	input  logic                               ready_req_i,
	input  logic                               ready_write_i,
	input  logic                               ready_read_i,
	input  logic [cache_pkg::BW_DATA-1:0]      data_i,
	output logic                               hit_o,
	output logic                               req_o,
	output logic                               req_block_o,
	output logic                               rw_o,
	output logic                               write_o,
	output logic                               read_o,
	output logic [cache_pkg::BW_WORD_ADDR-1:0] add_o,
	output logic [cache_pkg::BW_DATA-1:0]      data_o
);

	import cache_pkg::*;

	localparam int BW_LINE = $clog2(CACHE_BLOCK_CAPACITY);

	// ------------------------------------------------------------
	// internal nets
	// ------------------------------------------------------------
	logic [BW_TAG-1:0]           cam_tag, victim_tag;
	logic                        cam_hit, cam_wren, cam_dirty_set, cam_touch;
	logic [BW_LINE-1:0]          cam_line, cam_wr_line, touch_line, victim_line;
	logic                        victim_valid, victim_dirty;
	logic [BW_LINE+BW_BLOCK-1:0] dmem_addr;    // {line, word}
	logic                        dmem_wren;
	logic [BW_DATA-1:0]          dmem_wdata, dmem_rdata;
	logic                        flag_hit, flag_miss, flag_wb;

	tag_cam_fa #(
		.CACHE_BLOCK_CAPACITY (CACHE_BLOCK_CAPACITY),
		.POLICY               (POLICY)
	) u_tag_cam (
		.clock_i (clock_i), .arst_n_i (arst_n_i),
		.tag_i (cam_tag), .wren_i (cam_wren), .line_i (cam_wr_line),
		.dirty_set_i (cam_dirty_set), .touch_i (cam_touch), .touch_line_i (touch_line),
		.hit_o (cam_hit), .line_o (cam_line),
		.victim_line_o (victim_line), .victim_valid_o (victim_valid),
		.victim_dirty_o (victim_dirty), .victim_tag_o (victim_tag)
	);

	cache_data_mem #(
		.CACHE_BLOCK_CAPACITY (CACHE_BLOCK_CAPACITY)
	) u_data_mem (
		.clock_i (clock_i), .addr_i (dmem_addr), .wren_i (dmem_wren),
		.data_i (dmem_wdata), .data_o (dmem_rdata)
	);

	cache_controller #(
		.CACHE_BLOCK_CAPACITY (CACHE_BLOCK_CAPACITY)
	) u_controller (
		.clock_i (clock_i), .arst_n_i (arst_n_i), .enable_i (en_i),
		.core_req_i (core_req_i), .core_rw_i (core_rw_i),
		.core_tag_i (core_add_i[BW_WORD_ADDR-1:BW_BLOCK]),   // tag part
		.core_word_i (core_add_i[BW_BLOCK-1:0]),             // word offset
		.core_data_i (core_data_i), .core_done_o (core_done_o),
		.core_hit_o (hit_o), .core_data_o (core_data_o),
		.cam_tag_o (cam_tag), .cam_hit_i (cam_hit), .cam_line_i (cam_line),
		.cam_wren_o (cam_wren), .cam_line_o (cam_wr_line),
		.cam_dirty_set_o (cam_dirty_set), .cam_touch_o (cam_touch),
		.cam_touch_line_o (touch_line), .cam_victim_line_i (victim_line),
		.cam_victim_valid_i (victim_valid), .cam_victim_dirty_i (victim_dirty),
		.cam_victim_tag_i (victim_tag),
		.mem_addr_o (dmem_addr), .mem_wren_o (dmem_wren),
		.mem_wdata_o (dmem_wdata), .mem_rdata_i (dmem_rdata),
		.mem_ready_i (ready_req_i), .mem_req_o (req_o), .mem_req_block_o (req_block_o),
		.mem_rw_o (rw_o), .mem_addr_block_o (add_o),
		.buffer_read_ready_i (ready_read_i), .buffer_data_i (data_i),
		.buffer_read_ack_o (read_o), .buffer_write_ready_i (ready_write_i),
		.buffer_data_o (data_o), .buffer_write_ack_o (write_o),
		.flag_hit_o (flag_hit), .flag_miss_o (flag_miss), .flag_wb_o (flag_wb)
	);

	cache_perf_counters u_perf (
		.clock_i (clock_i), .arst_n_i (arst_n_i),
		.hit_i (flag_hit), .miss_i (flag_miss), .writeback_i (flag_wb),
		.metric_sel_i (metric_sel_i), .comm_i (comm_i), .comm_o (comm_o)
	);

endmodule

/* src/cache_perf_counters.sv */
`timescale 1ns/1ps

module cache_perf_counters (
	input  logic        clock_i,
	input  logic        arst_n_i,
	input  logic        hit_i,          // one pulse per event
	input  logic        miss_i,
	input  logic        writeback_i,
	input  logic [1:0]  metric_sel_i,   // 0 hit, 1 miss, 2 wb
	input  logic [31:0] comm_i,
	output logic [31:0] comm_o
);

	import cache_pkg::*;

	comm_op_e    op;
	logic [31:0] hit_cnt_q;
	logic [31:0] miss_cnt_q;
	logic [31:0] wb_cnt_q;
	logic [31:0] sel_cnt;

	// saturate at all ones
	function automatic logic [31:0] sat_inc(input logic [31:0] val, input logic en);
		return (en && (val != '1)) ? val + 1'b1 : val;
	endfunction

	assign op = comm_op_e'(comm_i[31:28]);

	always_comb begin
		case (metric_sel_i)
			2'd0:    sel_cnt = hit_cnt_q;
			2'd1:    sel_cnt = miss_cnt_q;
			2'd2:    sel_cnt = wb_cnt_q;
			default: sel_cnt = '0;
		endcase
	end

	// ------------------------------------------------------------
	// counters and registered reply
	// ------------------------------------------------------------
	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			hit_cnt_q  <= '0;
			miss_cnt_q <= '0;
			wb_cnt_q   <= '0;
			comm_o     <= '0;
		end else if (op == CMD_CLEAR) begin
			hit_cnt_q  <= '0;
			miss_cnt_q <= '0;
			wb_cnt_q   <= '0;
			comm_o     <= '0;
		end else begin
			hit_cnt_q  <= sat_inc(hit_cnt_q, hit_i);
			miss_cnt_q <= sat_inc(miss_cnt_q, miss_i);
			wb_cnt_q   <= sat_inc(wb_cnt_q, writeback_i);
			if (op == CMD_READ)
				comm_o <= sel_cnt;          // held until next read
		end
	end

endmodule

/* src/cache_controller.sv */
`timescale 1ns/1ps

module cache_controller #(
	parameter int CACHE_BLOCK_CAPACITY = 8
)(
	input  logic                                    clock_i,
	input  logic                                    arst_n_i,
	input  logic                                    enable_i,

	// core side
	input  logic                                    core_req_i,
	input  logic                                    core_rw_i,      // 1 write
	input  logic [cache_pkg::BW_TAG-1:0]            core_tag_i,
	input  logic [cache_pkg::BW_BLOCK-1:0]          core_word_i,
	input  logic [cache_pkg::BW_DATA-1:0]           core_data_i,
	output logic                                    core_done_o,
	output logic                                    core_hit_o,
	output logic [cache_pkg::BW_DATA-1:0]           core_data_o,

	// tag cam
	output logic [cache_pkg::BW_TAG-1:0]            cam_tag_o,
	input  logic                                    cam_hit_i,
	input  logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0] cam_line_i,
	output logic                                    cam_wren_o,
	output logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0] cam_line_o,
	output logic                                    cam_dirty_set_o,
	output logic                                    cam_touch_o,
	output logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0] cam_touch_line_o,
	input  logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0] cam_victim_line_i,
	input  logic                                    cam_victim_valid_i,
	input  logic                                    cam_victim_dirty_i,
	input  logic [cache_pkg::BW_TAG-1:0]            cam_victim_tag_i,

	// data memory
	output logic [$clog2(CACHE_BLOCK_CAPACITY)+cache_pkg::BW_BLOCK-1:0] mem_addr_o,
	output logic                                    mem_wren_o,
	output logic [cache_pkg::BW_DATA-1:0]           mem_wdata_o,
	input  logic [cache_pkg::BW_DATA-1:0]           mem_rdata_i,

	// external buffer
	input  logic                                    mem_ready_i,    // command accepted
	output logic                                    mem_req_o,
	output logic                                    mem_req_block_o,
	output logic                                    mem_rw_o,
	output logic [cache_pkg::BW_WORD_ADDR-1:0]      mem_addr_block_o,
	input  logic                                    buffer_read_ready_i,
	input  logic [cache_pkg::BW_DATA-1:0]           buffer_data_i,
	output logic                                    buffer_read_ack_o,
	input  logic                                    buffer_write_ready_i,
	output logic [cache_pkg::BW_DATA-1:0]           buffer_data_o,
	output logic                                    buffer_write_ack_o,

	// perf flags
	output logic                                    flag_hit_o,
	output logic                                    flag_miss_o,
	output logic                                    flag_wb_o
);

	import cache_pkg::*;

	localparam int                BW_LINE   = $clog2(CACHE_BLOCK_CAPACITY);
	localparam logic [BW_BLOCK-1:0] LAST_WORD = BW_BLOCK'(BLOCK_WORDS - 1);

	ctrl_state_e         state_q, state_d;
	logic [BW_BLOCK-1:0] cnt_q, cnt_d;          // word within block transfer
	logic                hit_q, hit_d;
	logic [BW_TAG-1:0]   req_tag_q;
	logic [BW_BLOCK-1:0] req_word_q;
	logic                req_rw_q;
	logic [BW_DATA-1:0]  req_data_q;
	logic [BW_LINE-1:0]  vic_line_q;
	logic [BW_TAG-1:0]   vic_tag_q;
	logic [BW_LINE-1:0]  acc_line;             // line touched this cycle

	// ------------------------------------------------------------
	// request and victim capture
	// ------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (state_q == IDLE) begin              // last value before LOOKUP is the sample
			req_tag_q  <= core_tag_i;
			req_word_q <= core_word_i;
			req_rw_q   <= core_rw_i;
			req_data_q <= core_data_i;
		end
		if (state_q == LOOKUP) begin
			vic_line_q <= cam_victim_line_i;
			vic_tag_q  <= cam_victim_tag_i;
		end
	end

	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= IDLE;
			cnt_q   <= '0;
			hit_q   <= 1'b0;
		end else begin
			state_q <= state_d;
			cnt_q   <= cnt_d;
			hit_q   <= hit_d;
		end
	end

	assign acc_line = (state_q == LOOKUP) ? cam_line_i : vic_line_q;

	assign cam_tag_o        = req_tag_q;
	assign cam_line_o       = acc_line;
	assign cam_touch_line_o = acc_line;
	assign core_done_o      = (state_q == RESPOND);
	assign core_hit_o       = hit_q;
	assign core_data_o      = mem_rdata_i;      // word addressed in the previous state
	assign buffer_data_o    = mem_rdata_i;      // pipelined victim word
	assign mem_req_block_o  = 1'b1;             // whole blocks only

	// ------------------------------------------------------------
	// next state and strobes
	// ------------------------------------------------------------
	always_comb begin
		state_d            = state_q;
		cnt_d              = cnt_q;
		hit_d              = hit_q;
		cam_wren_o         = 1'b0;
		cam_dirty_set_o    = 1'b0;
		cam_touch_o        = 1'b0;
		mem_addr_o         = {acc_line, req_word_q};
		mem_wren_o         = 1'b0;
		mem_wdata_o        = req_data_q;
		mem_req_o          = 1'b0;
		mem_rw_o           = 1'b0;
		mem_addr_block_o   = {req_tag_q, {BW_BLOCK{1'b0}}};
		buffer_read_ack_o  = 1'b0;
		buffer_write_ack_o = 1'b0;
		flag_hit_o         = 1'b0;
		flag_miss_o        = 1'b0;
		flag_wb_o          = 1'b0;

		case (state_q)
			IDLE: begin
				if (enable_i && core_req_i)
					state_d = LOOKUP;
			end
			LOOKUP: begin
				hit_d = cam_hit_i;
				cnt_d = '0;
				if (cam_hit_i) begin
					flag_hit_o  = 1'b1;
					cam_touch_o = 1'b1;
					state_d     = RESPOND;
					if (req_rw_q) begin             // write hit, word and dirty bit
						mem_wren_o      = 1'b1;
						cam_dirty_set_o = 1'b1;
					end
				end else begin
					flag_miss_o = 1'b1;
					if (cam_victim_valid_i && cam_victim_dirty_i)
						state_d = WB_REQ;
					else
						state_d = FILL_REQ;
				end
			end
			WB_REQ: begin
				mem_req_o        = 1'b1;
				mem_rw_o         = 1'b1;
				mem_addr_block_o = {vic_tag_q, {BW_BLOCK{1'b0}}};
				mem_addr_o       = {vic_line_q, {BW_BLOCK{1'b0}}};  // word 0 ready for WB_DATA
				if (mem_ready_i) begin
					flag_wb_o = 1'b1;
					state_d   = WB_DATA;
				end
			end
			WB_DATA: begin
				// read one word ahead, hold address while stalled
				mem_addr_o         = {vic_line_q, cnt_q + BW_BLOCK'(buffer_write_ready_i)};
				buffer_write_ack_o = buffer_write_ready_i;
				if (buffer_write_ready_i) begin
					cnt_d = cnt_q + 1'b1;
					if (cnt_q == LAST_WORD)
						state_d = FILL_REQ;
				end
			end
			FILL_REQ: begin
				mem_req_o = 1'b1;                   // read, address of request
				if (mem_ready_i)
					state_d = FILL_DATA;
			end
			FILL_DATA: begin
				mem_addr_o  = {vic_line_q, cnt_q};
				mem_wdata_o = buffer_data_i;
				if (buffer_read_ready_i) begin
					buffer_read_ack_o = 1'b1;
					mem_wren_o        = 1'b1;
					cnt_d             = cnt_q + 1'b1;
					if (cnt_q == LAST_WORD)
						state_d = UPDATE;
				end
			end
			UPDATE: begin
				cam_wren_o  = 1'b1;                 // install new tag in victim line
				cam_touch_o = 1'b1;
				if (req_rw_q) begin                 // merge the core word
					mem_wren_o      = 1'b1;
					cam_dirty_set_o = 1'b1;
				end
				state_d = RESPOND;
			end
			RESPOND: state_d = IDLE;
			default: state_d = IDLE;
		endcase
	end

endmodule

/* src/cache_data_mem.sv */
`timescale 1ns/1ps

module cache_data_mem #(
	parameter int CACHE_BLOCK_CAPACITY = 8
)(
	input  logic                                                       clock_i,
	input  logic [$clog2(CACHE_BLOCK_CAPACITY)+cache_pkg::BW_BLOCK-1:0] addr_i,  // {line, word}
	input  logic                                                       wren_i,
	input  logic [cache_pkg::BW_DATA-1:0]                              data_i,
	output logic [cache_pkg::BW_DATA-1:0]                              data_o
);

	import cache_pkg::*;

	localparam int DEPTH = CACHE_BLOCK_CAPACITY * BLOCK_WORDS;

	logic [BW_DATA-1:0] mem_q [DEPTH];

	// single port, read-first, maps onto block ram
	always_ff @(posedge clock_i) begin
		if (wren_i)
			mem_q[addr_i] <= data_i;
		data_o <= mem_q[addr_i];            // one cycle read latency
	end

endmodule

/* src/tag_cam_fa.sv */
`timescale 1ns/1ps

module tag_cam_fa #(
	parameter int                      CACHE_BLOCK_CAPACITY = 8,
	parameter cache_pkg::repl_policy_e POLICY               = cache_pkg::REPL_FIFO
)(
	input  logic                                    clock_i,
	input  logic                                    arst_n_i,
	input  logic [cache_pkg::BW_TAG-1:0]            tag_i,          // lookup and install tag
	input  logic                                    wren_i,         // install tag_i at line_i
	input  logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0] line_i,
	input  logic                                    dirty_set_i,    // mark line_i dirty
	input  logic                                    touch_i,        // access, for lru ages
	input  logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0] touch_line_i,
	output logic                                    hit_o,
	output logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0] line_o,         // matching line
	output logic [$clog2(CACHE_BLOCK_CAPACITY)-1:0] victim_line_o,
	output logic                                    victim_valid_o,
	output logic                                    victim_dirty_o,
	output logic [cache_pkg::BW_TAG-1:0]            victim_tag_o
);

	import cache_pkg::*;

	localparam int BW_LINE = $clog2(CACHE_BLOCK_CAPACITY);

	logic [BW_TAG-1:0]               tag_q [CACHE_BLOCK_CAPACITY];
	logic [CACHE_BLOCK_CAPACITY-1:0] valid_q;
	logic [CACHE_BLOCK_CAPACITY-1:0] dirty_q;
	logic [BW_LINE-1:0]              age_q [CACHE_BLOCK_CAPACITY];  // 0 = youngest
	logic [BW_LINE-1:0]              rr_ptr_q;                      // fifo pointer
	logic                            inv_found;
	logic [BW_LINE-1:0]              inv_line;
	logic [BW_LINE-1:0]              old_line;

	// ------------------------------------------------------------
	// parallel compare
	// ------------------------------------------------------------
	always_comb begin
		hit_o  = 1'b0;
		line_o = '0;
		for (int i = 0; i < CACHE_BLOCK_CAPACITY; i++) begin
			if (valid_q[i] && (tag_q[i] == tag_i)) begin
				hit_o  = 1'b1;
				line_o = BW_LINE'(i);
			end
		end
	end

	// ------------------------------------------------------------
	// victim selection
	// ------------------------------------------------------------
	always_comb begin
		inv_found = 1'b0;
		inv_line  = '0;
		old_line  = '0;
		for (int i = CACHE_BLOCK_CAPACITY - 1; i >= 0; i--) begin
			if (!valid_q[i]) begin                                  // lowest free line wins
				inv_found = 1'b1;
				inv_line  = BW_LINE'(i);
			end
			if (age_q[i] == BW_LINE'(CACHE_BLOCK_CAPACITY - 1))
				old_line = BW_LINE'(i);                             // ages are a permutation
		end
	end

	assign victim_line_o  = inv_found ? inv_line :
		(POLICY == REPL_LRU) ? old_line : rr_ptr_q;
	assign victim_valid_o = valid_q[victim_line_o];
	assign victim_dirty_o = dirty_q[victim_line_o];
	assign victim_tag_o   = tag_q[victim_line_o];

	// tag storage, no reset
	always_ff @(posedge clock_i) begin
		if (wren_i)
			tag_q[line_i] <= tag_i;
	end

	always_ff @(posedge clock_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			valid_q  <= '0;
			dirty_q  <= '0;
			rr_ptr_q <= '0;
			for (int i = 0; i < CACHE_BLOCK_CAPACITY; i++)
				age_q[i] <= BW_LINE'(i);
		end else begin
			if (wren_i) begin
				valid_q[line_i] <= 1'b1;
				dirty_q[line_i] <= 1'b0;     // fresh block is clean
				rr_ptr_q        <= rr_ptr_q + 1'b1;
			end
			if (dirty_set_i)
				dirty_q[line_i] <= 1'b1;     // wins over install clear
			if (touch_i) begin
				for (int i = 0; i < CACHE_BLOCK_CAPACITY; i++) begin
					if (BW_LINE'(i) == touch_line_i)
						age_q[i] <= '0;
					else if (age_q[i] < age_q[touch_line_i])
						age_q[i] <= age_q[i] + 1'b1;   // younger lines age by one
				end
			end
		end
	end

endmodule

/* src/cache_pkg.sv */
package cache_pkg;

	// ------------------------------------------------------------
	// address and data geometry
	// ------------------------------------------------------------
	localparam int BW_WORD_ADDR = 16;                  // word addressed core space
	localparam int BW_BLOCK     = 2;                   // word offset within a block
	localparam int BLOCK_WORDS  = 4;                   // 1 << BW_BLOCK
	localparam int BW_TAG       = BW_WORD_ADDR - BW_BLOCK;
	localparam int BW_DATA      = 32;

	// ------------------------------------------------------------
	// controller states
	// ------------------------------------------------------------
	typedef enum logic [2:0] {
		IDLE,       // wait for a core request
		LOOKUP,     // cam compare, hit handled here
		RESPOND,    // done pulse to the core
		WB_REQ,     // writeback command to buffer
		WB_DATA,    // stream dirty victim out
		FILL_REQ,   // refill command to buffer
		FILL_DATA,  // take refill words in
		UPDATE      // install tag, finish the access
	} ctrl_state_e;

	// ------------------------------------------------------------
	// comm port opcodes, comm_i[31:28]
	// ------------------------------------------------------------
	typedef enum logic [3:0] {
		CMD_NOP   = 4'h0,
		CMD_READ  = 4'h1,   // return counter picked by metric_sel_i
		CMD_CLEAR = 4'h2    // zero all counters
	} comm_op_e;

	// replacement choice once every line is valid
	typedef enum logic {
		REPL_FIFO,
		REPL_LRU
	} repl_policy_e;

endpackage
